//--- source/backend_pkg.sv
`default_nettype none

package backend_pkg;

    localparam int CACHE_LINES = 16;
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = 32 - INDEX_BITS - 2; // above index and byte offset
    localparam int LINK_OFFSET = 4;
    localparam int REG_COUNT   = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_num_t;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_t;

    // integer destination source
    typedef enum logic [1:0] {
        src_alu,
        src_mem,
        src_link,
        src_falu
    } rd_src_t;

    typedef enum logic [1:0] {
        fsrc_falu,
        fsrc_move, // integer rt value
        fsrc_mem
    } frd_src_t;

    typedef struct packed {
        mem_op_t  mem_op;
        logic     is_word;     // lw/sw, else lb/sb
        word_t    alu_result;  // also the memory address
        word_t    rt_data;
        word_t    falu_result;
        word_t    inst_addr;
        reg_num_t rd_num;
        logic     reg_write;
        logic     freg_write;
        rd_src_t  register_src;
        frd_src_t fregister_src;
        logic     halted;
    } ex_bundle_t;

    typedef struct packed {
        logic       is_word;
        word_t      alu_result;
        word_t      rt_data;
        word_t      falu_result;
        word_t      inst_addr;
        reg_num_t   rd_num;
        logic       reg_write;
        logic       freg_write;
        rd_src_t    register_src;
        frd_src_t   fregister_src;
        logic       halted;
        word_t      load_word;
        logic [1:0] byte_number; // 0 is the most significant byte
    } mem_wb_t;

    typedef struct packed {
        logic     en;
        reg_num_t num;
        word_t    data;
    } reg_write_t;

endpackage

`default_nettype wire

//--- source/data_cache.sv
`default_nettype none
`timescale 1ns/10ps

module data_cache import backend_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire ex_bundle_t mem_bundle,
    input  wire logic       mem_valid,
    input  wire logic       mem_ack,
    input  wire word_t      mem_rdata,
    output word_t           cache_rdata,
    output logic            cache_hit,
    output logic            cache_busy,
    output logic            mem_req,
    output logic            mem_we,
    output word_t           mem_addr,
    output word_t           mem_wdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_release,
        st_done
    } state_t;

    logic [CACHE_LINES-1:0] line_valid;
    logic [TAG_BITS-1:0]    line_tag  [CACHE_LINES];
    word_t                  line_data [CACHE_LINES];

    state_t                 state;
    logic                   rmw_read;   // sb miss reads the word before writing it
    word_t                  fetch_word;
    logic [INDEX_BITS-1:0]  index;
    logic [TAG_BITS-1:0]    tag;
    logic                   is_load;
    logic                   is_store;
    word_t                  base_word;
    word_t                  store_word;

    assign index    = mem_bundle.alu_result[INDEX_BITS+1:2];
    assign tag      = mem_bundle.alu_result[31:INDEX_BITS+2];
    assign is_load  = mem_valid && mem_bundle.mem_op == mem_load;
    assign is_store = mem_valid && mem_bundle.mem_op == mem_store;

    assign cache_rdata = line_data[index];
    assign cache_hit   = mem_valid && line_valid[index] && line_tag[index] == tag;
    // drops only in the cycle the last handshake has finished
    assign cache_busy  = state != st_done;

    // word the stored byte is merged into
    assign base_word = cache_hit ? line_data[index] : fetch_word;

    always_comb
    begin
        store_word = base_word;
        if (mem_bundle.is_word)
            store_word = mem_bundle.rt_data;
        else
        begin
            case (mem_bundle.alu_result[1:0])
                2'd0:    store_word[31:24] = mem_bundle.rt_data[7:0]; // msb lane
                2'd1:    store_word[23:16] = mem_bundle.rt_data[7:0];
                2'd2:    store_word[15:8]  = mem_bundle.rt_data[7:0];
                default: store_word[7:0]   = mem_bundle.rt_data[7:0];
            endcase
        end
    end

    assign mem_req   = state == st_request;
    assign mem_we    = is_store && !rmw_read;
    assign mem_addr  = {mem_bundle.alu_result[31:2], 2'b00};
    assign mem_wdata = store_word;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= st_idle;
            rmw_read <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if ((is_load && !cache_hit) || is_store)
                    begin
                        rmw_read <= is_store && !mem_bundle.is_word && !cache_hit;
                        state    <= st_request;
                    end
                end
                st_request:
                begin
                    if (mem_ack)
                        state <= st_release;
                end
                st_release:
                begin
                    if (!mem_ack) // ack low, next req allowed
                    begin
                        rmw_read <= 1'b0;
                        state    <= (is_store && rmw_read) ? st_request : st_done;
                    end
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_request && mem_ack && !mem_we)
            fetch_word <= mem_rdata; // valid while ack is high
        if (state == st_done)
        begin
            if (is_load)
            begin
                line_tag[index]  <= tag;
                line_data[index] <= fetch_word;
            end
            else if (is_store && cache_hit)
                line_data[index] <= store_word; // no allocate on store miss
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            line_valid <= '0;
        else if (state == st_done && is_load)
            line_valid[index] <= 1'b1;
    end

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`default_nettype none
`timescale 1ns/10ps

module mem_stage import backend_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire ex_bundle_t ex_bundle,
    input  wire logic       ex_valid,
    input  wire word_t      cache_rdata,
    input  wire logic       cache_hit,
    input  wire logic       cache_busy,
    output ex_bundle_t      mem_bundle,
    output logic            mem_valid,
    output mem_wb_t         wb_bundle,
    output logic            wb_valid,
    output logic            stall,
    output logic            halted
);

    logic    mem_wait;     // EX/MEM instruction stays this cycle
    logic    halt_pending;
    logic    advance;
    mem_wb_t wb_next;

    always_comb
    begin
        mem_wait = 1'b0;
        if (mem_valid)
        begin
            case (mem_bundle.mem_op)
                mem_load:  mem_wait = !cache_hit; // refill first
                mem_store: mem_wait = cache_busy; // until write-through ends
                default:   mem_wait = 1'b0;
            endcase
        end
    end

    // nothing younger than a halt is taken in
    assign halt_pending = (mem_valid && mem_bundle.halted) || (wb_valid && wb_bundle.halted);
    assign advance      = mem_valid && !mem_wait;
    assign stall        = halted || halt_pending || mem_wait;

    always_comb
    begin
        wb_next.is_word       = mem_bundle.is_word;
        wb_next.alu_result    = mem_bundle.alu_result;
        wb_next.rt_data       = mem_bundle.rt_data;
        wb_next.falu_result   = mem_bundle.falu_result;
        wb_next.inst_addr     = mem_bundle.inst_addr;
        wb_next.rd_num        = mem_bundle.rd_num;
        wb_next.reg_write     = mem_bundle.reg_write;
        wb_next.freg_write    = mem_bundle.freg_write;
        wb_next.register_src  = mem_bundle.register_src;
        wb_next.fregister_src = mem_bundle.fregister_src;
        wb_next.halted        = mem_bundle.halted;
        wb_next.load_word     = cache_rdata;
        wb_next.byte_number   = mem_bundle.alu_result[1:0];
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
            halted    <= 1'b0;
        end
        else
        begin
            if (!stall)
                mem_valid <= ex_valid;
            else if (!mem_wait)
                mem_valid <= 1'b0; // drained behind a halt
            wb_valid <= advance;   // bubble otherwise
            if (wb_valid && wb_bundle.halted)
                halted <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
            mem_bundle <= ex_bundle;
        if (advance)
            wb_bundle <= wb_next;
    end

endmodule

`default_nettype wire

//--- source/writeback.sv
`default_nettype none
`timescale 1ns/10ps

module writeback import backend_pkg::*;
(
    input  wire mem_wb_t  wb_bundle,
    input  wire logic     wb_valid,
    output reg_write_t    int_write,
    output reg_write_t    fp_write
);

    logic [7:0] load_byte;
    word_t      load_value;
    word_t      rd_data;
    word_t      frd_data;

    // big-endian lanes
    always_comb
    begin
        case (wb_bundle.byte_number)
            2'd0:    load_byte = wb_bundle.load_word[31:24];
            2'd1:    load_byte = wb_bundle.load_word[23:16];
            2'd2:    load_byte = wb_bundle.load_word[15:8];
            default: load_byte = wb_bundle.load_word[7:0];
        endcase
        if (wb_bundle.is_word)
            load_value = wb_bundle.load_word;
        else
            load_value = {{24{load_byte[7]}}, load_byte}; // lb sign extends
    end

    always_comb
    begin
        case (wb_bundle.register_src)
            src_alu:  rd_data = wb_bundle.alu_result;
            src_mem:  rd_data = load_value;
            src_link: rd_data = wb_bundle.inst_addr + word_t'(LINK_OFFSET);
            src_falu: rd_data = wb_bundle.falu_result;
            default:  rd_data = wb_bundle.alu_result;
        endcase
    end

    always_comb
    begin
        case (wb_bundle.fregister_src)
            fsrc_falu: frd_data = wb_bundle.falu_result;
            fsrc_move: frd_data = wb_bundle.rt_data;
            fsrc_mem:  frd_data = load_value; // memory result to the fp side
            default:   frd_data = wb_bundle.falu_result;
        endcase
    end

    always_comb
    begin
        int_write.en   = wb_valid && wb_bundle.reg_write;
        int_write.num  = wb_bundle.rd_num;
        int_write.data = rd_data;
        fp_write.en    = wb_valid && wb_bundle.freg_write;
        fp_write.num   = wb_bundle.rd_num;
        fp_write.data  = frd_data;
    end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none
`timescale 1ns/10ps

module reg_file import backend_pkg::*;
#(
    parameter bit zero_reg = 1'b0 // register 0 hardwired to zero
)
(
    input  wire logic       clk,
    input  wire reg_write_t wr,
    input  wire reg_num_t   ra_num,
    input  wire reg_num_t   rb_num,
    output word_t           ra_data,
    output word_t           rb_data
);

    word_t regs [REG_COUNT];
    logic  wr_take;

    assign wr_take = wr.en && !(zero_reg && wr.num == '0);

    function automatic word_t read_port(reg_num_t num);
        word_t value;
        if (zero_reg && num == '0)
            value = '0;
        else if (wr_take && wr.num == num)
            value = wr.data; // same-cycle write seen at once
        else
            value = regs[num];
        return value;
    endfunction

    always_comb
    begin
        ra_data = read_port(ra_num);
    end

    always_comb
    begin
        rb_data = read_port(rb_num);
    end

    always_ff @(posedge clk)
    begin
        if (wr_take)
            regs[wr.num] <= wr.data;
    end

endmodule

`default_nettype wire

//--- source/backend_top.sv
`default_nettype none
`timescale 1ns/10ps

module backend_top import backend_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire ex_bundle_t ex_bundle,
    input  wire logic       ex_valid,
    input  wire reg_num_t   rs_num,
    input  wire reg_num_t   rt_num,
    input  wire reg_num_t   frs_num,
    input  wire reg_num_t   frt_num,
    input  wire logic       mem_ack,
    input  wire word_t      mem_rdata,
    output logic            stall,
    output logic            halted,
    output word_t           rs_data,
    output word_t           rt_data,
    output word_t           frs_data,
    output word_t           frt_data,
    output logic            mem_req,
    output logic            mem_we,
    output word_t           mem_addr,
    output word_t           mem_wdata
);

    ex_bundle_t mem_bundle;
    logic       mem_valid;
    mem_wb_t    wb_bundle;
    logic       wb_valid;
    word_t      cache_rdata;
    logic       cache_hit;
    logic       cache_busy;
    reg_write_t int_write;
    reg_write_t fp_write;

    mem_stage mem_stg (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_bundle   (ex_bundle),
        .ex_valid    (ex_valid),
        .cache_rdata (cache_rdata),
        .cache_hit   (cache_hit),
        .cache_busy  (cache_busy),
        .mem_bundle  (mem_bundle),
        .mem_valid   (mem_valid),
        .wb_bundle   (wb_bundle),
        .wb_valid    (wb_valid),
        .stall       (stall),
        .halted      (halted)
    );

    data_cache dcache (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_bundle  (mem_bundle),
        .mem_valid   (mem_valid),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .cache_rdata (cache_rdata),
        .cache_hit   (cache_hit),
        .cache_busy  (cache_busy),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    writeback wb_sel (
        .wb_bundle (wb_bundle),
        .wb_valid  (wb_valid),
        .int_write (int_write),
        .fp_write  (fp_write)
    );

    reg_file #(.zero_reg(1'b1)) int_regs (
        .clk     (clk),
        .wr      (int_write),
        .ra_num  (rs_num),
        .rb_num  (rt_num),
        .ra_data (rs_data),
        .rb_data (rt_data)
    );

    reg_file #(.zero_reg(1'b0)) fp_regs (
        .clk     (clk),
        .wr      (fp_write),
        .ra_num  (frs_num),
        .rb_num  (frt_num),
        .ra_data (frs_data),
        .rb_data (frt_data)
    );

endmodule

`default_nettype wire

//--- test/mem_model.sv
`default_nettype none
`timescale 1ns/10ps

module mem_model import backend_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  req,
    input  wire logic  we,
    input  wire word_t addr,
    input  wire word_t wdata,
    output logic       ack,
    output word_t      rdata
);

    localparam int mem_words = 256;

    word_t words [mem_words]; // word address is addr[9:2]
    int    read_count;
    int    write_count;

    initial
    begin
        int delay;
        ack         = 1'b0;
        rdata       = '0;
        read_count  = 0;
        write_count = 0;
        delay       = $urandom(9); // seed once
        for (int i = 0; i < mem_words; i++)
            words[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 7)};
        forever
        begin
            @(posedge clk);
            #10;
            if (req)
            begin
                delay = $urandom % 4; // 0 to 3 cycles before ack
                repeat (delay)
                begin
                    @(posedge clk);
                    #10;
                end
                if (we)
                begin
                    words[addr[9:2]] = wdata;
                    write_count++;
                end
                else
                begin
                    rdata = words[addr[9:2]];
                    read_count++;
                end
                ack = 1'b1;
                while (req)
                begin
                    @(posedge clk);
                    #10;
                end
                ack = 1'b0; // req dropped, finish the four phases
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_backend.sv
`default_nettype none
`timescale 1ns/10ps

module tb_backend import backend_pkg::*;
();

    localparam int clk_period      = 100;
    localparam int instr_total     = 22;
    localparam int watchdog_cycles = instr_total * 50 + 100;

    logic       clk;
    logic       rst_n;
    ex_bundle_t ex_bundle;
    logic       ex_valid;
    reg_num_t   rs_num;
    reg_num_t   rt_num;
    reg_num_t   frs_num;
    reg_num_t   frt_num;
    logic       mem_ack;
    word_t      mem_rdata;
    logic       stall;
    logic       halted;
    word_t      rs_data;
    word_t      rt_data;
    word_t      frs_data;
    word_t      frt_data;
    logic       mem_req;
    logic       mem_we;
    word_t      mem_addr;
    word_t      mem_wdata;
    int         errors;
    int         checks;

    backend_top dut (.*);

    mem_model mem (
        .clk   (clk),
        .req   (mem_req),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .ack   (mem_ack),
        .rdata (mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("** FAIL **");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAILED %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAILED %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_int(input reg_num_t num, input word_t expected);
        rs_num = num;
        rt_num = num; // both decode ports
        #1;
        check_word($sformatf("rs_data r%0d", num), expected, rs_data);
        check_word($sformatf("rt_data r%0d", num), expected, rt_data);
    endtask

    task automatic check_fp(input reg_num_t num, input word_t expected);
        frs_num = num;
        frt_num = num;
        #1;
        check_word($sformatf("frs_data f%0d", num), expected, frs_data);
        check_word($sformatf("frt_data f%0d", num), expected, frt_data);
    endtask

    function automatic ex_bundle_t load_bundle(word_t addr, logic is_word, reg_num_t rd);
        ex_bundle_t b;
        b              = '0;
        b.mem_op       = mem_load;
        b.is_word      = is_word;
        b.alu_result   = addr;
        b.rd_num       = rd;
        b.reg_write    = 1'b1;
        b.register_src = src_mem;
        return b;
    endfunction

    function automatic ex_bundle_t store_bundle(word_t addr, logic is_word, word_t data);
        ex_bundle_t b;
        b            = '0;
        b.mem_op     = mem_store;
        b.is_word    = is_word;
        b.alu_result = addr;
        b.rt_data    = data;
        return b;
    endfunction

    // byte 0 is the top byte of the word
    function automatic word_t lb_value(word_t word, logic [1:0] lane);
        word_t shifted;
        shifted = word >> (8 * (3 - int'(lane)));
        return {{24{shifted[7]}}, shifted[7:0]};
    endfunction

    function automatic word_t merge_byte(word_t word, logic [1:0] lane, logic [7:0] value);
        int shift;
        shift = 8 * (3 - int'(lane));
        return (word & ~(32'hff << shift)) | (word_t'(value) << shift);
    endfunction

    task automatic issue(input ex_bundle_t b);
        logic taken;
        ex_bundle = b;
        ex_valid  = 1'b1;
        taken     = 1'b0;
        while (!taken)
        begin
            taken = !stall; // accepted at the coming edge
            next_cycle();
        end
        ex_valid = 1'b0;
    endtask

    task automatic wait_retire();
        while (stall)
            next_cycle();
        repeat (2)
            next_cycle(); // into MEM/WB, then register write
    endtask

    task automatic run_and_check(input ex_bundle_t b, input word_t expected);
        issue(b);
        wait_retire();
        if (b.freg_write)
            check_fp(b.rd_num, expected);
        else
            check_int(b.rd_num, expected);
    endtask

    task automatic run_store(input ex_bundle_t b);
        issue(b);
        check_bit("stall on store", 1'b1, stall); // held until write-through ends
        wait_retire();
    endtask

    task automatic test_int_sources();
        ex_bundle_t b;
        b              = '0;
        b.reg_write    = 1'b1;
        b.rd_num       = 5'd5;
        b.alu_result   = 32'h1234_5678;
        b.inst_addr    = 32'h0000_0400;
        b.falu_result  = 32'hc0a0_0000;
        run_and_check(b, b.alu_result);
        b.rd_num       = 5'd31;
        b.register_src = src_link;
        run_and_check(b, b.inst_addr + 4);
        b.rd_num       = 5'd7;
        b.register_src = src_falu;
        run_and_check(b, b.falu_result);
        b.rd_num       = 5'd0;
        b.register_src = src_alu;
        run_and_check(b, '0); // r0 stays zero
    endtask

    task automatic test_fp_sources();
        ex_bundle_t b;
        b             = '0;
        b.freg_write  = 1'b1;
        b.rd_num      = 5'd2;
        b.falu_result = 32'h3f80_0000;
        b.rt_data     = 32'h4049_0fdb;
        run_and_check(b, b.falu_result);
        b.rd_num        = 5'd3;
        b.fregister_src = fsrc_move;
        run_and_check(b, b.rt_data);
        mem.words[8'h40] = 32'h4120_0000; // address 0x100
        b               = load_bundle(32'h100, 1'b1, 5'd4);
        b.reg_write     = 1'b0;
        b.freg_write    = 1'b1;
        b.fregister_src = fsrc_mem;
        run_and_check(b, 32'h4120_0000);
    endtask

    task automatic test_miss_hit();
        int reads;
        mem.words[8'h41] = 32'h8765_4321; // address 0x104
        reads = mem.read_count;
        issue(load_bundle(32'h104, 1'b1, 5'd8));
        check_bit("stall on miss", 1'b1, stall);
        wait_retire();
        check_int(5'd8, 32'h8765_4321);
        check_word("mem read_count", reads + 1, mem.read_count);
        issue(load_bundle(32'h104, 1'b1, 5'd9));
        check_bit("stall on hit", 1'b0, stall);
        wait_retire();
        check_int(5'd9, 32'h8765_4321);
        check_word("mem read_count", reads + 1, mem.read_count);
    endtask

    task automatic test_byte_loads();
        word_t word;
        word = 32'h807f_c315;
        mem.words[8'h42] = word; // address 0x108
        for (int lane = 0; lane < 4; lane++)
            run_and_check(load_bundle(32'h108 + lane, 1'b0, reg_num_t'(10 + lane)),
                          lb_value(word, lane[1:0]));
    endtask

    task automatic test_write_through();
        word_t expected;
        int    reads;
        int    writes;
        // 0x104 is cached from the miss test
        expected = merge_byte(32'h8765_4321, 2'd1, 8'ha6);
        reads    = mem.read_count;
        writes   = mem.write_count;
        run_store(store_bundle(32'h105, 1'b0, 32'h1234_56a6));
        check_word("mem word 0x104", expected, mem.words[8'h41]);
        check_word("mem write_count", writes + 1, mem.write_count);
        run_and_check(load_bundle(32'h104, 1'b1, 5'd14), expected);
        check_word("mem read_count", reads, mem.read_count);
        // sw miss, same index as 0x100 with another tag
        run_store(store_bundle(32'h140, 1'b1, 32'hcafe_f00d));
        check_word("mem word 0x140", 32'hcafe_f00d, mem.words[8'h50]);
        run_and_check(load_bundle(32'h140, 1'b1, 5'd15), 32'hcafe_f00d);
        mem.words[8'h60] = 32'h1122_3344; // address 0x180, not cached
        expected = merge_byte(32'h1122_3344, 2'd3, 8'hee);
        run_store(store_bundle(32'h183, 1'b0, 32'h0000_00ee));
        check_word("mem word 0x180", expected, mem.words[8'h60]);
        run_and_check(load_bundle(32'h180, 1'b1, 5'd16), expected);
    endtask

    task automatic test_halt();
        ex_bundle_t b;
        ex_bundle_t halt_b;
        b            = '0;
        b.reg_write  = 1'b1;
        b.rd_num     = 5'd21;
        b.alu_result = 32'h2121_2121;
        run_and_check(b, b.alu_result);
        halt_b        = '0;
        halt_b.halted = 1'b1;
        issue(halt_b);
        while (!halted)
            next_cycle();
        check_bit("stall", 1'b1, stall);
        b.alu_result = 32'h9999_9999; // must never retire
        ex_bundle    = b;
        ex_valid     = 1'b1;
        repeat (5)
            next_cycle();
        ex_valid = 1'b0;
        check_bit("halted", 1'b1, halted);
        check_bit("stall", 1'b1, stall);
        check_int(5'd21, 32'h2121_2121);
    endtask

    initial
    begin
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        ex_bundle = '0;
        ex_valid  = 1'b0;
        rs_num    = '0;
        rt_num    = '0;
        frs_num   = '0;
        frt_num   = '0;
        repeat (5)
            @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_bit("stall", 1'b0, stall);
        check_bit("mem_req", 1'b0, mem_req);
        check_bit("halted", 1'b0, halted);
        test_int_sources();
        test_fp_sources();
        test_miss_hit();
        test_byte_loads();
        test_write_through();
        test_halt();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/backend_pkg.sv
source/data_cache.sv
source/mem_stage.sv
source/writeback.sv
source/reg_file.sv
source/backend_top.sv
test/mem_model.sv
test/tb_backend.sv
